// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module display_tb -Mdir obj_dir -f sim.f
	@out=$$(./obj_dir/Vdisplay_tb); echo "$$out"; \
		echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: hdl/calc_data_pkg.sv
`default_nettype none

// values handed to the display by the keypad entry and arithmetic blocks
package calc_data_pkg;

    // one hex or BCD digit
    typedef logic [3:0] digit_t;

    // full arithmetic result, shown as two pages of four hex digits
    typedef logic [31:0] result_t;

    // operand digits as the keypad entry block delivers them
    typedef struct packed {
        digit_t thousands;  // leftmost
        digit_t hundreds;
        digit_t tens;
        digit_t ones;       // rightmost
    } operand_digits_t;

    // bit ranges of the two result pages
    localparam int RESULT_HIGH_MSB = 31;
    localparam int RESULT_HIGH_LSB = 16;
    localparam int RESULT_LOW_MSB  = 15;
    localparam int RESULT_LOW_LSB  = 0;

endpackage

`default_nettype wire

// File: hdl/digit_select.sv
`default_nettype none

module digit_select import calc_data_pkg::*, display_pkg::*; (
    input  logic            clk_100mhz,
    input  logic            reset,
    input  view_t           view,
    input  operand_digits_t operand_in,
    input  result_t         result_in,
    output shown_digits_t   shown
);

    shown_digits_t shown_next;

    always_comb begin
        case (view)
            VIEW_RESULT_HIGH:
                shown_next = shown_digits_t'(result_in[RESULT_HIGH_MSB:RESULT_HIGH_LSB]);
            VIEW_RESULT_LOW:
                shown_next = shown_digits_t'(result_in[RESULT_LOW_MSB:RESULT_LOW_LSB]);
            default: begin
                shown_next.digit_3 = operand_in.thousands;
                shown_next.digit_2 = operand_in.hundreds;
                shown_next.digit_1 = operand_in.tens;
                shown_next.digit_0 = operand_in.ones;
            end
        endcase
    end

    // one cycle behind view and the data inputs
    always_ff @(posedge clk_100mhz) begin
        if (reset)
            shown <= '0;
        else
            shown <= shown_next;
    end

endmodule

`default_nettype wire

// File: hdl/display_pkg.sv
`default_nettype none

// display hardware vectors and the view state of the display block
package display_pkg;

    import calc_data_pkg::*;

    typedef logic [6:0] seg_t;    // active low, {g,f,e,d,c,b,a}
    typedef logic [3:0] anode_t;  // active low, bit 0 is the rightmost digit
    typedef logic [1:0] leds_t;   // mode LEDs

    localparam leds_t LEDS_INPUT       = 2'b00;
    localparam leds_t LEDS_RESULT_HIGH = 2'b10;
    localparam leds_t LEDS_RESULT_LOW  = 2'b01;

    typedef enum logic [1:0] {
        VIEW_INPUT,
        VIEW_RESULT_HIGH,
        VIEW_RESULT_LOW
    } view_t;

    // digits currently on the display, leftmost first
    typedef struct packed {
        digit_t digit_3;  // leftmost, anode bit 3
        digit_t digit_2;
        digit_t digit_1;
        digit_t digit_0;  // rightmost, anode bit 0
    } shown_digits_t;

endpackage

`default_nettype wire

// File: hdl/display_top.sv
`default_nettype none

module display_top import calc_data_pkg::*, display_pkg::*; #(
    parameter int REFRESH_DIV = 100_000  // board clock cycles per digit
) (
    input  logic            clk_100mhz,
    input  logic            reset,
    input  logic            select,           // 0 operand, 1 result
    input  logic            advance_display,  // next result page
    input  result_t         result_in,
    input  operand_digits_t operand_in,
    output anode_t          an_out,
    output seg_t            seg_out,
    output leds_t           leds_out          // current view
);

    logic          scan_tick;
    view_t         view;
    shown_digits_t shown;

    refresh_timer #(
        .REFRESH_DIV(REFRESH_DIV)
    ) i_refresh_timer (
        .clk_100mhz(clk_100mhz),
        .reset     (reset),
        .scan_tick (scan_tick)
    );

    view_fsm i_view_fsm (
        .clk_100mhz     (clk_100mhz),
        .reset          (reset),
        .select         (select),
        .advance_display(advance_display),
        .view           (view),
        .leds_out       (leds_out)
    );

    digit_select i_digit_select (
        .clk_100mhz(clk_100mhz),
        .reset     (reset),
        .view      (view),
        .operand_in(operand_in),
        .result_in (result_in),
        .shown     (shown)
    );

    seg7_scan i_seg7_scan (
        .clk_100mhz(clk_100mhz),
        .reset     (reset),
        .scan_tick (scan_tick),
        .shown     (shown),
        .an_out    (an_out),
        .seg_out   (seg_out)
    );

endmodule

`default_nettype wire

// File: hdl/refresh_timer.sv
`default_nettype none

module refresh_timer #(
    parameter int REFRESH_DIV = 100_000
) (
    input  logic clk_100mhz,
    input  logic reset,
    output logic scan_tick
);

    localparam int CNT_W = (REFRESH_DIV > 1) ? $clog2(REFRESH_DIV) : 1;

    logic [CNT_W-1:0] count;
    logic             wrap;

    assign wrap = (count == CNT_W'(REFRESH_DIV - 1));

    // tick is registered, so it lands REFRESH_DIV cycles after reset drops
    always_ff @(posedge clk_100mhz) begin
        if (reset) begin
            count     <= '0;
            scan_tick <= 1'b0;
        end else begin
            scan_tick <= wrap;
            if (wrap)
                count <= '0;
            else
                count <= count + 1'b1;
        end
    end

    // the scanner relies on a single-cycle strobe
    a_tick_single: assert property (@(posedge clk_100mhz) disable iff (reset)
        scan_tick |=> !scan_tick);

endmodule

`default_nettype wire

// File: hdl/seg7_scan.sv
`default_nettype none

module seg7_scan import calc_data_pkg::*, display_pkg::*; (
    input  logic          clk_100mhz,
    input  logic          reset,
    input  logic          scan_tick,
    input  shown_digits_t shown,
    output anode_t        an_out,
    output seg_t          seg_out
);

    logic [1:0] pos;  // 0 is the rightmost digit
    digit_t     cur_digit;

    // hex to active-low segments, {g,f,e,d,c,b,a}
    function automatic seg_t hex_to_seg(input digit_t d);
        case (d)
            4'h0:    return 7'b1000000;
            4'h1:    return 7'b1111001;
            4'h2:    return 7'b0100100;
            4'h3:    return 7'b0110000;
            4'h4:    return 7'b0011001;
            4'h5:    return 7'b0010010;
            4'h6:    return 7'b0000010;
            4'h7:    return 7'b1111000;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0010000;
            4'hA:    return 7'b0001000;
            4'hB:    return 7'b0000011;  // lower case b
            4'hC:    return 7'b1000110;
            4'hD:    return 7'b0100001;  // lower case d
            4'hE:    return 7'b0000110;
            default: return 7'b0001110;  // F
        endcase
    endfunction

    always_comb begin
        case (pos)
            2'd0:    cur_digit = shown.digit_0;
            2'd1:    cur_digit = shown.digit_1;
            2'd2:    cur_digit = shown.digit_2;
            default: cur_digit = shown.digit_3;
        endcase
    end

    // light the current position, then step on to the next one left
    always_ff @(posedge clk_100mhz) begin
        if (reset) begin
            pos     <= 2'd0;
            an_out  <= '1;  // all digits dark until the first tick
            seg_out <= '1;
        end else if (scan_tick) begin
            an_out  <= ~(anode_t'(1) << pos);
            seg_out <= hex_to_seg(cur_digit);
            pos     <= pos + 2'd1;  // wraps from leftmost back to rightmost
        end
    end

    a_one_anode: assert property (@(posedge clk_100mhz) disable iff (reset)
        $countones(~an_out) <= 1);

endmodule

`default_nettype wire

// File: hdl/view_fsm.sv
`default_nettype none

module view_fsm import display_pkg::*; (
    input  logic  clk_100mhz,
    input  logic  reset,
    input  logic  select,           // 0 shows the operand, 1 the result
    input  logic  advance_display,  // button, already debounced
    output view_t view,
    output leds_t leds_out
);

    view_t view_next;
    logic  select_q;   // previous sample of select
    logic  advance_q;  // previous sample of the button
    logic  select_rise;
    logic  advance_rise;

    assign select_rise  = select && !select_q;
    assign advance_rise = advance_display && !advance_q;

    always_ff @(posedge clk_100mhz) begin
        if (reset) begin
            view      <= VIEW_INPUT;
            select_q  <= 1'b0;
            advance_q <= 1'b0;
        end else begin
            view      <= view_next;
            select_q  <= select;
            advance_q <= advance_display;
        end
    end

    always_comb begin
        view_next = view;
        if (!select) begin
            view_next = VIEW_INPUT;
        end else if (select_rise) begin
            view_next = VIEW_RESULT_HIGH;  // a new result view always starts on the high page
        end else begin
            case (view)
                VIEW_INPUT:       view_next = VIEW_RESULT_HIGH;
                VIEW_RESULT_HIGH: if (advance_rise) view_next = VIEW_RESULT_LOW;
                VIEW_RESULT_LOW:  if (advance_rise) view_next = VIEW_RESULT_HIGH;
                default:          view_next = VIEW_INPUT;
            endcase
        end
    end

    // LEDs follow the state directly
    always_comb begin
        case (view)
            VIEW_RESULT_HIGH: leds_out = LEDS_RESULT_HIGH;
            VIEW_RESULT_LOW:  leds_out = LEDS_RESULT_LOW;
            default:          leds_out = LEDS_INPUT;
        endcase
    end

    a_leds_legal: assert property (@(posedge clk_100mhz) disable iff (reset)
        leds_out != 2'b11);

endmodule

`default_nettype wire

// File: sim.f
hdl/calc_data_pkg.sv
hdl/display_pkg.sv
hdl/refresh_timer.sv
hdl/view_fsm.sv
hdl/digit_select.sv
hdl/seg7_scan.sv
hdl/display_top.sv
sim/tb_clock.sv
sim/display_tb.sv

// File: sim/display_tb.sv
`default_nettype none

module display_tb import calc_data_pkg::*, display_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int REFRESH_DIV  = 16;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_STEPS    = 13;
    localparam int STEP_CYCLES  = 10 * REFRESH_DIV;  // apply, settle, one full scan and margin

    // lit segments {g,f,e,d,c,b,a} for digits 0 to F
    localparam seg_t LIT [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                                  7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

    typedef enum logic [1:0] {RES_KEEP, RES_TABLE, RES_RANDOM} res_src_t;

    typedef struct packed {
        logic            sel;
        logic            pulse;       // one press of advance_display
        operand_digits_t operand;
        res_src_t        res_src;
        result_t         res_word;
        leds_t           exp_leds;
        shown_digits_t   exp_digits;  // used in input view only
    } step_t;

    logic            clk;
    logic            reset;
    logic            select;
    logic            advance_display;
    result_t         result_in;
    operand_digits_t operand_in;
    anode_t          an_out;
    seg_t            seg_out;
    leds_t           leds_out;
    step_t           steps [NUM_STEPS];
    result_t         rng_state;
    result_t         cur_result;  // word currently driven on result_in

    tb_clock #(.RESET_CYCLES(RESET_CYCLES)) i_clock (.clk(clk), .reset(reset));

    display_top #(.REFRESH_DIV(REFRESH_DIV)) i_dut (
        .clk_100mhz     (clk),
        .reset          (reset),
        .select         (select),
        .advance_display(advance_display),
        .result_in      (result_in),
        .operand_in     (operand_in),
        .an_out         (an_out),
        .seg_out        (seg_out),
        .leds_out       (leds_out)
    );

    function automatic result_t next_random(input result_t x);
        result_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic check_leds(input leds_t actual, input leds_t expected, input string ctx);
        if (actual !== expected)
            report_mismatch($sformatf("%s, leds_out %b, expected %b", ctx, actual, expected));
    endtask

    task automatic check_anodes(input anode_t actual, input anode_t expected, input string ctx);
        if (actual !== expected)
            report_mismatch($sformatf("%s, an_out %b, expected %b", ctx, actual, expected));
    endtask

    task automatic check_segments(input seg_t actual, input seg_t expected, input int pos,
                                  input string ctx);
        if (actual !== expected)
            report_mismatch($sformatf("%s, seg_out %b at digit %0d, expected %b",
                                      ctx, actual, pos, expected));
    endtask

    // follow four ticks as the lit digit moves one place left on each
    task automatic watch_scan(input shown_digits_t want, input string ctx);
        anode_t prev;
        int     pos;
        pos = 0;
        if ($countones(~an_out) != 1)
            report_mismatch($sformatf("%s, an_out %b does not enable exactly one digit",
                                      ctx, an_out));
        for (int t = 0; t < 4; t++) begin
            prev = an_out;
            do @(negedge clk); while (an_out === prev);  // next tick
            check_anodes(an_out, {prev[2:0], prev[3]}, ctx);
            for (int k = 0; k < 4; k++)
                if (!an_out[k]) pos = k;
            check_segments(seg_out, ~LIT[want[4*pos +: 4]], pos, ctx);
        end
    endtask

    task automatic apply_step(input step_t s);
        @(negedge clk);
        if (s.res_src == RES_RANDOM)
            rng_state = next_random(rng_state);
        if (s.res_src == RES_TABLE)
            cur_result = s.res_word;
        else if (s.res_src == RES_RANDOM)
            cur_result = rng_state;
        select     = s.sel;
        operand_in = s.operand;
        result_in  = cur_result;
        if (s.pulse) begin
            @(negedge clk);
            advance_display = 1'b1;
            @(negedge clk);
            advance_display = 1'b0;
        end
    endtask

    initial begin
        shown_digits_t want;
        select          = 1'b0;
        advance_display = 1'b0;
        result_in       = '0;
        operand_in      = '0;
        rng_state       = 32'd28604;
        cur_result      = '0;

        // select, pulse, operand, result source, result word, leds, input view digits
        steps[0]  = '{1'b0, 1'b0, 16'h1234, RES_TABLE,  32'h0000_0000, 2'b00, 16'h1234};
        steps[1]  = '{1'b0, 1'b0, 16'hABCD, RES_KEEP,   32'h0000_0000, 2'b00, 16'hABCD};
        steps[2]  = '{1'b0, 1'b0, 16'hEF09, RES_KEEP,   32'h0000_0000, 2'b00, 16'hEF09};
        steps[3]  = '{1'b1, 1'b0, 16'hEF09, RES_RANDOM, 32'h0000_0000, 2'b10, 16'h0000};
        steps[4]  = '{1'b1, 1'b1, 16'hEF09, RES_KEEP,   32'h0000_0000, 2'b01, 16'h0000};
        steps[5]  = '{1'b1, 1'b1, 16'hEF09, RES_KEEP,   32'h0000_0000, 2'b10, 16'h0000};
        steps[6]  = '{1'b1, 1'b1, 16'hEF09, RES_KEEP,   32'h0000_0000, 2'b01, 16'h0000};
        steps[7]  = '{1'b0, 1'b0, 16'h5678, RES_KEEP,   32'h0000_0000, 2'b00, 16'h5678};
        steps[8]  = '{1'b1, 1'b0, 16'h5678, RES_KEEP,   32'h0000_0000, 2'b10, 16'h0000};
        steps[9]  = '{1'b1, 1'b0, 16'h5678, RES_RANDOM, 32'h0000_0000, 2'b10, 16'h0000};
        steps[10] = '{1'b1, 1'b1, 16'h5678, RES_RANDOM, 32'h0000_0000, 2'b01, 16'h0000};
        steps[11] = '{1'b1, 1'b0, 16'h5678, RES_TABLE,  32'h1234_ABCD, 2'b01, 16'h0000};
        steps[12] = '{1'b0, 1'b0, 16'h9876, RES_KEEP,   32'h0000_0000, 2'b00, 16'h9876};

        wait (reset == 1'b0);
        @(negedge clk);  // first cycle out of reset, before any tick
        check_leds(leds_out, 2'b00, "after reset");
        check_anodes(an_out, 4'b1111, "after reset");
        check_segments(seg_out, 7'h7F, 0, "after reset");

        for (int i = 0; i < NUM_STEPS; i++) begin
            apply_step(steps[i]);
            repeat (5 * REFRESH_DIV) @(negedge clk);
            if (steps[i].exp_leds == 2'b00)
                want = steps[i].exp_digits;
            else if (steps[i].exp_leds == 2'b10)
                want = cur_result[31:16];  // high page
            else
                want = cur_result[15:0];
            check_leds(leds_out, steps[i].exp_leds, $sformatf("step %0d", i));
            watch_scan(want, $sformatf("step %0d", i));
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + 4 + NUM_STEPS * STEP_CYCLES) @(posedge clk);
        $display("timeout: the display sequence did not complete in the allowed time");
        stop_with_failure();
    end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`default_nettype none

// 8 ns clock and a synchronous reset for the display testbench
module tb_clock #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;  // dropped on a falling edge with the other inputs
    end

endmodule

`default_nettype wire
